// File: Bender.yml
package:
  name: riscv_id_stage

sources:
  - include_dirs:
      - design
    files:
      - design/riscv_isa_pkg.sv
      - design/riscv_ctrl_pkg.sv
      - design/riscv_id_imm.sv
      - design/riscv_id_opt.sv
      - design/riscv_idu.sv
      - design/riscv_regfile.sv
      - design/riscv_id_stage.sv
  - target: test
    files:
      - tb/riscv_id_stage_tb.sv

// File: design/riscv_ctrl_pkg.sv
package riscv_ctrl_pkg;

  import riscv_isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10 // lui.
  } alu_opt_e;

  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2
  } src_a_e;

  // four gives the link address for jal and jalr.
  typedef enum logic [1:0] {
    SRC_B_RS2  = 2'd0,
    SRC_B_IMM  = 2'd1,
    SRC_B_FOUR = 2'd2
  } src_b_e;

  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LH   = 4'd2,
    LSU_LW   = 4'd3,
    LSU_LBU  = 4'd4,
    LSU_LHU  = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_opt_e;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     rd_wen;
    xlen_t    imm;
    alu_opt_e alu_opt;
    src_a_e   src_a;
    src_b_e   src_b;
    lsu_opt_e lsu_opt;
    funct3_t  funct3; // kept for branch compare and lsu.
    logic     branch;
    logic     jal;
    logic     jalr;
    logic     illegal;
  } id_ctrl_t;

  typedef struct packed {
    id_ctrl_t ctrl;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
  } id_out_t;

endpackage

// File: design/riscv_id_imm.sv
`timescale 1ns/1ps

module riscv_id_imm
  import riscv_isa_pkg::*;
(
  input  inst_t   inst,
  input  opcode_e opcode,
  output xlen_t   imm
);

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};

  // b and j are halfword offsets, bit 0 is implied zero.
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OPC_LUI,
      OPC_AUIPC: begin
        imm = imm_u;
      end
      OPC_JAL: begin
        imm = imm_j;
      end
      OPC_JALR,
      OPC_LOAD,
      OPC_OP_IMM,
      OPC_SYS: begin
        imm = imm_i; // sys carries the csr address here.
      end
      OPC_STORE: begin
        imm = imm_s;
      end
      OPC_BRANCH: begin
        imm = imm_b;
      end
      default: begin
        imm = '0; // op, fence and unknown.
      end
    endcase
  end

endmodule

// File: design/riscv_id_opt.sv
`timescale 1ns/1ps

module riscv_id_opt
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  opcode_e    opcode,
  input  funct3_t    funct3,
  input  logic [6:0] funct7,
  output alu_opt_e   alu_opt,
  output src_a_e     src_a,
  output src_b_e     src_b,
  output lsu_opt_e   lsu_opt
);

  // shared by op and op_imm, only op may select sub.
  function automatic alu_opt_e alu_from_f3(
    input funct3_t f3,
    input logic    alt,
    input logic    is_reg
  );
    alu_opt_e op;
    case (f3)
      F3_ADD:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  always_comb begin
    alu_opt = ALU_ADD;
    src_a   = SRC_A_RS1;
    src_b   = SRC_B_RS2;
    lsu_opt = LSU_NONE;
    case (opcode)
      OPC_LUI: begin
        src_a   = SRC_A_ZERO;
        src_b   = SRC_B_IMM;
        alu_opt = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        src_a = SRC_A_PC;
        src_b = SRC_B_IMM;
      end
      OPC_JAL,
      OPC_JALR: begin
        src_a = SRC_A_PC; // pc + 4 goes to rd.
        src_b = SRC_B_FOUR;
      end
      OPC_BRANCH: begin
        case (funct3)
          F3_BEQ,
          F3_BNE:  alu_opt = ALU_SUB;
          F3_BLT,
          F3_BGE:  alu_opt = ALU_SLT;
          F3_BLTU,
          F3_BGEU: alu_opt = ALU_SLTU;
          default: alu_opt = ALU_SUB;
        endcase
      end
      OPC_LOAD: begin
        src_b = SRC_B_IMM;
        case (funct3)
          F3_B:    lsu_opt = LSU_LB;
          F3_H:    lsu_opt = LSU_LH;
          F3_W:    lsu_opt = LSU_LW;
          F3_BU:   lsu_opt = LSU_LBU;
          F3_HU:   lsu_opt = LSU_LHU;
          default: lsu_opt = LSU_NONE;
        endcase
      end
      OPC_STORE: begin
        src_b = SRC_B_IMM;
        case (funct3)
          F3_B:    lsu_opt = LSU_SB;
          F3_H:    lsu_opt = LSU_SH;
          F3_W:    lsu_opt = LSU_SW;
          default: lsu_opt = LSU_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        src_b   = SRC_B_IMM;
        alu_opt = alu_from_f3(funct3, funct7[5], 1'b0);
      end
      OPC_OP: begin
        alu_opt = alu_from_f3(funct3, funct7[5], 1'b1);
      end
      default: begin
        alu_opt = ALU_ADD; // fence, sys and unknown keep the defaults.
      end
    endcase
  end

endmodule

// File: design/riscv_id_stage.sv
`timescale 1ns/1ps

module riscv_id_stage
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  inst_t    inst,
  input  logic     stall,
  input  logic     wb_wen,
  input  reg_idx_t wb_rd,
  input  xlen_t    wb_data,
  output logic     out_valid,
  output id_out_t  out
);

  id_ctrl_t ctrl;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  logic     accept;

  riscv_idu u_idu (
    .inst (inst),
    .ctrl (ctrl)
  );

  // read addresses come straight from the decoded fields.
  riscv_regfile u_regfile (
    .clk (clk),
    .rst (rst),
    .ra1 (ctrl.rs1),
    .ra2 (ctrl.rs2),
    .rd1 (rs1_data),
    .rd2 (rs2_data),
    .wen (wb_wen),
    .wa  (wb_rd),
    .wd  (wb_data)
  );

  assign accept = in_valid && !stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (!stall) begin
      out_valid <= in_valid;
    end
  end

  // payload only moves on an accepted instruction.
  always_ff @(posedge clk) begin
    if (accept) begin
      out.ctrl     <= ctrl;
      out.rs1_data <= rs1_data;
      out.rs2_data <= rs2_data;
    end
  end

  a_valid_after_rst: assert property (
    @(posedge clk) rst |=> !out_valid
  );

  // held output, nothing leaks through while stalled.
  a_stall_hold: assert property (
    @(posedge clk) disable iff (rst)
    stall |=> $stable(out_valid) && $stable(out)
  );

endmodule

// File: design/riscv_idu.sv
`timescale 1ns/1ps

module riscv_idu
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  inst_t    inst,
  output id_ctrl_t ctrl
);

  opcode_e    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  logic       rd_wen;
  logic       illegal;
  xlen_t      imm;
  alu_opt_e   alu_opt;
  src_a_e     src_a;
  src_b_e     src_b;
  lsu_opt_e   lsu_opt;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields per opcode.
  always_comb begin
    rs1     = '0;
    rs2     = '0;
    rd      = '0;
    rd_wen  = 1'b0;
    illegal = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_JAL: begin
        rd     = inst[11:7];
        rd_wen = 1'b1;
      end
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
        rs1    = inst[19:15];
        rd     = inst[11:7];
        rd_wen = 1'b1;
      end
      OPC_BRANCH, OPC_STORE: begin
        rs1 = inst[19:15];
        rs2 = inst[24:20];
      end
      OPC_OP: begin
        rs1    = inst[19:15];
        rs2    = inst[24:20];
        rd     = inst[11:7];
        rd_wen = 1'b1;
      end
      OPC_FENCE: begin
        rd_wen = 1'b0;
      end
      OPC_SYS: begin
        rs1 = inst[19:15]; // fields kept, no write.
        rd  = inst[11:7];
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  riscv_id_imm u_imm (
    .inst   (inst),
    .opcode (opcode),
    .imm    (imm)
  );

  riscv_id_opt u_opt (
    .opcode  (opcode),
    .funct3  (funct3),
    .funct7  (funct7),
    .alu_opt (alu_opt),
    .src_a   (src_a),
    .src_b   (src_b),
    .lsu_opt (lsu_opt)
  );

  always_comb begin
    ctrl.rs1     = rs1;
    ctrl.rs2     = rs2;
    ctrl.rd      = rd;
    ctrl.rd_wen  = rd_wen;
    ctrl.imm     = imm;
    ctrl.alu_opt = alu_opt;
    ctrl.src_a   = src_a;
    ctrl.src_b   = src_b;
    ctrl.lsu_opt = lsu_opt;
    ctrl.funct3  = illegal ? '0 : funct3;
    ctrl.branch  = (opcode == OPC_BRANCH);
    ctrl.jal     = (opcode == OPC_JAL);
    ctrl.jalr    = (opcode == OPC_JALR);
    ctrl.illegal = illegal;
  end

  // only one redirect kind per instruction, across the opt and imm paths too.
  always_comb begin
    assert final ($onehot0({ctrl.branch, ctrl.jal, ctrl.jalr})
                  && ((ctrl.jal || ctrl.jalr) == (ctrl.src_b == SRC_B_FOUR))
                  && !((ctrl.branch || ctrl.jal) && ctrl.imm[0]));
  end

endmodule

// File: design/riscv_isa_pkg.sv
`include "riscv_macros.svh"

package riscv_isa_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`INST_WIDTH-1:0] inst_t;
  typedef logic [`REG_WIDTH-1:0]  reg_idx_t;
  typedef logic [2:0]             funct3_t;

  // base opcodes, inst[6:0].
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_FENCE  = 7'b0001111,
    OPC_SYS    = 7'b1110011
  } opcode_e;

  // alu funct3 of OP and OP_IMM.
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101; // srl or sra, by funct7.
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // memory access size.
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // branch conditions.
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

endpackage

// File: design/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath width of the core.
`define XLEN 32

// one uncompressed instruction.
`define INST_WIDTH 32

// register index, x0 to x31.
`define REG_WIDTH 5

`define NR_REGS 32 // architectural integer registers.

`endif

// File: design/riscv_regfile.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_regfile
  import riscv_isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  output xlen_t    rd1,
  output xlen_t    rd2,
  input  logic     wen,
  input  reg_idx_t wa,
  input  xlen_t    wd
);

  xlen_t regs [`NR_REGS];
  logic  wr_ok;

  assign wr_ok = wen && (wa != '0); // x0 is never written.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NR_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wa] <= wd;
    end
  end

  // write-through, same cycle write shows on the read port.
  assign rd1 = (wr_ok && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (wr_ok && wa == ra2) ? wd : regs[ra2];

  // x0 reads zero even while a write targets it.
  a_x0_rd1: assert property (
    @(posedge clk) disable iff (rst)
    (ra1 == '0) |-> (rd1 == '0)
  );

  a_x0_rd2: assert property (
    @(posedge clk) disable iff (rst)
    (ra2 == '0) |-> (rd2 == '0)
  );

endmodule

// File: tb/riscv_id_stage_tb.sv
`timescale 1ns/1ps

module riscv_id_stage_tb
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
();

  // reset, then the six tests in order.
  localparam int test_cycles = 5 + 34 + 96 + 80 + 112 + 104 + 14;
  localparam int max_cycles  = 2 * test_cycles;

  localparam logic [6:0] opc_list [12] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
    OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYS, 7'b1111111};
  localparam logic [6:0] imm_opc [5] = '{OPC_OP_IMM, OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_JAL};

  // expected operation per funct3.
  localparam alu_opt_e f3_alu [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                      ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  localparam alu_opt_e br_alu [8] = '{ALU_SUB, ALU_SUB, ALU_SUB, ALU_SUB,
                                      ALU_SLT, ALU_SLT, ALU_SLTU, ALU_SLTU};
  localparam lsu_opt_e ld_lsu [8] = '{LSU_LB, LSU_LH, LSU_LW, LSU_NONE,
                                      LSU_LBU, LSU_LHU, LSU_NONE, LSU_NONE};
  localparam lsu_opt_e st_lsu [8] = '{LSU_SB, LSU_SH, LSU_SW, LSU_NONE,
                                      LSU_NONE, LSU_NONE, LSU_NONE, LSU_NONE};

  logic     clk;
  logic     rst;
  logic     in_valid;
  inst_t    inst;
  logic     stall;
  logic     wb_wen;
  reg_idx_t wb_rd;
  xlen_t    wb_data;
  logic     out_valid;
  id_out_t  out;

  xlen_t       shadow [32]; // expected register contents.
  logic [31:0] lfsr = 32'hb672c56a;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;

  riscv_id_stage dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .inst      (inst),
    .stall     (stall),
    .wb_wen    (wb_wen),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .out_valid (out_valid),
    .out       (out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("Something failed");
      $finish;
    end
  end

  // galois lfsr, one step per bit taken.
  function automatic xlen_t rnd(input int n);
    xlen_t v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic xlen_t sext(input xlen_t v, input int bits);
    return xlen_t'($signed(v << (32 - bits)) >>> (32 - bits));
  endfunction

  function automatic inst_t op_inst(input reg_idx_t rs1, input reg_idx_t rs2,
                                    input reg_idx_t rd);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'(OPC_OP)};
  endfunction

  function automatic id_ctrl_t ref_decode(input inst_t i);
    id_ctrl_t   c;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       has_rs1;
    logic       has_rs2;
    logic       has_rd;
    opc = i[6:0];
    f3  = i[14:12];
    c   = '0;
    if (!(opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                      OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE, OPC_SYS})) begin
      c.illegal = 1'b1; // all other fields stay cleared.
      return c;
    end
    has_rs1 = opc inside {OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_BRANCH, OPC_STORE, OPC_OP,
                          OPC_SYS};
    has_rs2 = opc inside {OPC_BRANCH, OPC_STORE, OPC_OP};
    has_rd  = opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM,
                          OPC_OP, OPC_SYS};
    c.rs1    = has_rs1 ? i[19:15] : '0;
    c.rs2    = has_rs2 ? i[24:20] : '0;
    c.rd     = has_rd ? i[11:7] : '0;
    c.rd_wen = has_rd && (opc != OPC_SYS);
    c.funct3 = f3;
    c.branch = (opc == OPC_BRANCH);
    c.jal    = (opc == OPC_JAL);
    c.jalr   = (opc == OPC_JALR);
    case (opc)
      OPC_LUI, OPC_AUIPC: c.imm = {i[31:12], 12'b0};
      OPC_JAL:            c.imm = sext({i[31], i[19:12], i[20], i[30:21], 1'b0}, 21);
      OPC_BRANCH:         c.imm = sext({i[31], i[7], i[30:25], i[11:8], 1'b0}, 13);
      OPC_STORE:          c.imm = sext({i[31:25], i[11:7]}, 12);
      OPC_OP, OPC_FENCE:  c.imm = '0;
      default:            c.imm = sext(i[31:20], 12);
    endcase
    c.src_a = (opc == OPC_LUI) ? SRC_A_ZERO :
              (opc inside {OPC_AUIPC, OPC_JAL, OPC_JALR}) ? SRC_A_PC : SRC_A_RS1;
    c.src_b = (opc inside {OPC_JAL, OPC_JALR}) ? SRC_B_FOUR :
              (opc inside {OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE, OPC_OP_IMM}) ? SRC_B_IMM :
              SRC_B_RS2;
    case (opc)
      OPC_LUI:            c.alu_opt = ALU_PASS_B;
      OPC_BRANCH:         c.alu_opt = br_alu[f3];
      OPC_LOAD:           c.lsu_opt = ld_lsu[f3];
      OPC_STORE:          c.lsu_opt = st_lsu[f3];
      OPC_OP_IMM, OPC_OP: c.alu_opt = f3_alu[f3];
      default:            c.alu_opt = ALU_ADD;
    endcase
    if (f3 == 3'd5 && i[30] && (opc inside {OPC_OP_IMM, OPC_OP})) begin
      c.alu_opt = ALU_SRA;
    end
    if (f3 == 3'd0 && i[30] && opc == OPC_OP) begin
      c.alu_opt = ALU_SUB;
    end
    return c;
  endfunction

  task automatic check(input string what, input logic [159:0] got, input logic [159:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one instruction, optionally with a write-back on the same edge.
  task automatic decode_check(input inst_t i, input logic wen, input reg_idx_t wa,
                              input xlen_t wd);
    id_ctrl_t exp;
    if (wen && wa != '0) begin
      shadow[wa] = wd; // write-through shows the new value at once.
    end
    exp = ref_decode(i);
    @(posedge clk);
    in_valid <= 1'b1;
    inst     <= i;
    wb_wen   <= wen;
    wb_rd    <= wa;
    wb_data  <= wd;
    @(posedge clk);
    in_valid <= 1'b0;
    wb_wen   <= 1'b0;
    @(negedge clk);
    check($sformatf("out_valid for %h", i), out_valid, 1'b1);
    check($sformatf("ctrl for %h", i), out.ctrl, exp);
    check($sformatf("rs1_data for %h", i), out.rs1_data, shadow[exp.rs1]);
    check($sformatf("rs2_data for %h", i), out.rs2_data, shadow[exp.rs2]);
  endtask

  task automatic write_reg(input reg_idx_t wa, input xlen_t wd);
    @(posedge clk);
    wb_wen  <= 1'b1;
    wb_rd   <= wa;
    wb_data <= wd;
    @(posedge clk);
    wb_wen <= 1'b0;
    if (wa != '0) begin
      shadow[wa] = wd;
    end
  endtask

  task automatic test_reset_and_zero();
    check("out_valid after reset", out_valid, 1'b0);
    for (int r = 0; r < 32; r += 2) begin
      decode_check(op_inst(reg_idx_t'(r), reg_idx_t'(r + 1), reg_idx_t'(rnd(5))),
                   1'b0, '0, '0);
    end
  endtask

  task automatic test_reg_fields();
    for (int k = 0; k < 12; k++) begin
      repeat (4) begin
        decode_check({25'(rnd(25)), opc_list[k]}, 1'b0, '0, '0);
      end
    end
  endtask

  task automatic test_immediates();
    logic [24:0] hi;
    for (int k = 0; k < 40; k++) begin
      hi     = 25'(rnd(25));
      hi[24] = k[0]; // both signs for every format.
      decode_check({hi, imm_opc[k % 5]}, 1'b0, '0, '0);
    end
  endtask

  task automatic test_alu_fields();
    logic [6:0] f7;
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        f7 = (alt != 0) ? 7'h20 : 7'h00;
        decode_check({f7, 10'(rnd(10)), 3'(f3), 5'(rnd(5)), 7'(OPC_OP)}, 1'b0, '0, '0);
        decode_check({f7, 10'(rnd(10)), 3'(f3), 5'(rnd(5)), 7'(OPC_OP_IMM)}, 1'b0, '0, '0);
      end
      decode_check({17'(rnd(17)), 3'(f3), 5'(rnd(5)), 7'(OPC_LOAD)}, 1'b0, '0, '0);
      decode_check({17'(rnd(17)), 3'(f3), 5'(rnd(5)), 7'(OPC_STORE)}, 1'b0, '0, '0);
      decode_check({17'(rnd(17)), 3'(f3), 5'(rnd(5)), 7'(OPC_BRANCH)}, 1'b0, '0, '0);
    end
  endtask

  task automatic test_writeback();
    reg_idx_t wa;
    for (int k = 0; k < 16; k++) begin
      wa = reg_idx_t'(rnd(5));
      write_reg(wa, rnd(32));
      decode_check(op_inst(wa, reg_idx_t'(rnd(5)), 5'd1), 1'b0, '0, '0);
      wa = reg_idx_t'(rnd(5)) | 5'd1;
      decode_check(op_inst(wa, wa, 5'd2), 1'b1, wa, rnd(32));
    end
    write_reg('0, 32'hffff_ffff);
    decode_check(op_inst('0, '0, 5'd3), 1'b0, '0, '0);
    decode_check(op_inst('0, 5'd1, 5'd3), 1'b1, '0, rnd(32)); // x0 hit on the decode edge.
  endtask

  task automatic test_stall();
    inst_t   first;
    inst_t   next;
    id_out_t held;
    first = op_inst(5'd4, 5'd5, 5'd6);
    next  = {25'(rnd(25)), 7'(OPC_LOAD)};
    @(posedge clk);
    in_valid <= 1'b1;
    inst     <= first;
    @(posedge clk);
    stall <= 1'b1;
    inst  <= {25'(rnd(25)), 7'(OPC_OP_IMM)};
    @(negedge clk);
    check("ctrl before stall", out.ctrl, ref_decode(first));
    held = out;
    repeat (4) begin
      @(posedge clk);
      in_valid <= ~in_valid; // valid toggles under the stall.
      inst     <= {25'(rnd(25)), 7'(OPC_STORE)};
      @(negedge clk);
      check("out_valid during stall", out_valid, 1'b1);
      check("out during stall", out, held);
    end
    @(posedge clk);
    stall    <= 1'b0;
    in_valid <= 1'b1;
    inst     <= next;
    @(negedge clk);
    check("out on release edge", out, held);
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check("out_valid after release", out_valid, 1'b1);
    check("ctrl after release", out.ctrl, ref_decode(next));
    @(posedge clk);
    @(negedge clk);
    check("out_valid when idle", out_valid, 1'b0);
  endtask

  initial begin
    rst      <= 1'b1;
    in_valid <= 1'b0;
    inst     <= '0;
    stall    <= 1'b0;
    wb_wen   <= 1'b0;
    wb_rd    <= '0;
    wb_data  <= '0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_reset_and_zero();
    test_reg_fields();
    test_immediates();
    test_alu_fields();
    test_writeback();
    test_stall();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+design
design/riscv_isa_pkg.sv
design/riscv_ctrl_pkg.sv
design/riscv_id_imm.sv
design/riscv_id_opt.sv
design/riscv_idu.sv
design/riscv_regfile.sv
design/riscv_id_stage.sv
tb/riscv_id_stage_tb.sv
